//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    input  rvPkg::decodeT          dec,
    output logic [rvPkg::XLEN-1:0] result,
    output logic                   branchTaken
);

    localparam int SHW = $clog2(rvPkg::XLEN);  // Shift amount width

    logic [rvPkg::XLEN-1:0] opA;
    logic [rvPkg::XLEN-1:0] opB;
    logic [SHW-1:0]         shamt;
    logic                   eq;
    logic                   ltS;  // Signed less than
    logic                   ltU;  // Unsigned less than

    // ------------------------------------------------
    // Operands and compares
    // ------------------------------------------------
    assign opA   = rs1Data;
    assign opB   = dec.aluSrc ? dec.imm : rs2Data;  // Immediate or rs2
    assign shamt = opB[SHW-1:0];                    // Low bits only

    assign eq  = (opA == opB);
    assign ltS = ($signed(opA) < $signed(opB));
    assign ltU = (opA < opB);

    // ------------------------------------------------
    // Result
    // ------------------------------------------------
    always_comb begin
        case (dec.aluOp)
            rvPkg::ADD:  result = opA + opB;
            rvPkg::SUB:  result = opA - opB;
            rvPkg::AND:  result = opA & opB;
            rvPkg::OR:   result = opA | opB;
            rvPkg::XOR:  result = opA ^ opB;
            rvPkg::SLL:  result = opA << shamt;
            rvPkg::SRL:  result = opA >> shamt;
            rvPkg::SRA:  result = $unsigned($signed(opA) >>> shamt);  // Sign fill
            rvPkg::SLT:  result = {{(rvPkg::XLEN-1){1'b0}}, ltS};
            rvPkg::SLTU: result = {{(rvPkg::XLEN-1){1'b0}}, ltU};
            default:     result = '0;  // NONE and illegal
        endcase
    end

    // Branch decision straight from compares
    always_comb begin
        branchTaken = 1'b0;
        if (dec.isBranch) begin
            case (dec.funct3)
                rvPkg::F3_BEQ:  branchTaken = eq;
                rvPkg::F3_BNE:  branchTaken = !eq;
                rvPkg::F3_BLT:  branchTaken = ltS;
                rvPkg::F3_BGE:  branchTaken = !ltS;
                rvPkg::F3_BLTU: branchTaken = ltU;
                rvPkg::F3_BGEU: branchTaken = !ltU;
                default:        branchTaken = 1'b0;
            endcase
        end
    end

endmodule

//--- execCtrl.sv
`timescale 1ns/1ps

module execCtrl (
    input  logic clk,
    input  logic arstN,
    input  logic instrValid,
    output logic latchEn,   // Capture instruction word
    output logic exeEn,     // Capture ALU outputs
    output logic wbEn,      // Commit register and pc
    output logic busy,
    output logic done
);

    rvPkg::ctrlStateE state;
    rvPkg::ctrlStateE stateNext;

    // ------------------------------------------------
    // State register
    // ------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= rvPkg::IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // Fixed four-cycle walk without back-pressure
    always_comb begin
        stateNext = state;
        case (state)
            rvPkg::IDLE: begin
                if (instrValid) begin
                    stateNext = rvPkg::DECODE;
                end
            end
            rvPkg::DECODE:    stateNext = rvPkg::EXECUTE;   // Decode and reg read settle
            rvPkg::EXECUTE:   stateNext = rvPkg::WRITEBACK;
            rvPkg::WRITEBACK: stateNext = rvPkg::IDLE;      // Ready again at this edge
            default:          stateNext = rvPkg::IDLE;
        endcase
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    assign latchEn = (state == rvPkg::IDLE) && instrValid;  // Strobes while busy dropped
    assign exeEn   = (state == rvPkg::EXECUTE);
    assign wbEn    = (state == rvPkg::WRITEBACK);
    assign done    = (state == rvPkg::WRITEBACK);
    assign busy    = (state != rvPkg::IDLE);

endmodule

//--- instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic [31:0]   instr,
    output rvPkg::decodeT dec
);

    rvPkg::opcodeE          opcode;
    logic [6:0]             funct7;
    logic                   f7Base;  // Funct7 all zero
    logic                   f7Alt;   // Only bit 5 set
    logic [rvPkg::XLEN-1:0] immI;
    logic [rvPkg::XLEN-1:0] immB;

    assign opcode = rvPkg::opcodeE'(instr[6:0]);
    assign funct7 = instr[31:25];
    assign f7Base = (funct7 == rvPkg::F7_BASE);
    assign f7Alt  = (funct7 == rvPkg::F7_ALT);

    // ------------------------------------------------
    // Immediates
    // ------------------------------------------------
    assign immI = {{20{instr[31]}}, instr[31:20]};
    // B form is scrambled with bit 0 always zero
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // ------------------------------------------------
    // Classification and ALU op select
    // ------------------------------------------------
    always_comb begin
        dec          = '0;
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.funct3   = instr[14:12];
        dec.aluOp    = rvPkg::NONE;

        case (opcode)
            rvPkg::OP_R: begin
                dec.regWrite = 1'b1;
                case (dec.funct3)
                    rvPkg::F3_ADD:  dec.aluOp = f7Alt ? rvPkg::SUB : rvPkg::ADD;
                    rvPkg::F3_SLL:  dec.aluOp = rvPkg::SLL;
                    rvPkg::F3_SLT:  dec.aluOp = rvPkg::SLT;
                    rvPkg::F3_SLTU: dec.aluOp = rvPkg::SLTU;
                    rvPkg::F3_XOR:  dec.aluOp = rvPkg::XOR;
                    rvPkg::F3_SR:   dec.aluOp = f7Alt ? rvPkg::SRA : rvPkg::SRL;
                    rvPkg::F3_OR:   dec.aluOp = rvPkg::OR;
                    rvPkg::F3_AND:  dec.aluOp = rvPkg::AND;
                endcase
                // Alt funct7 only valid for SUB and SRA
                dec.illegal = !(f7Base || (f7Alt && (dec.funct3 == rvPkg::F3_ADD ||
                                                     dec.funct3 == rvPkg::F3_SR)));
            end

            rvPkg::OP_I: begin
                dec.aluSrc   = 1'b1;
                dec.imm      = immI;
                dec.regWrite = 1'b1;
                case (dec.funct3)
                    rvPkg::F3_ADD:  dec.aluOp = rvPkg::ADD;
                    rvPkg::F3_SLT:  dec.aluOp = rvPkg::SLT;   // SLTI
                    rvPkg::F3_SLTU: dec.aluOp = rvPkg::SLTU;
                    rvPkg::F3_XOR:  dec.aluOp = rvPkg::XOR;
                    rvPkg::F3_OR:   dec.aluOp = rvPkg::OR;
                    rvPkg::F3_AND:  dec.aluOp = rvPkg::AND;
                    rvPkg::F3_SLL: begin
                        dec.aluOp   = rvPkg::SLL;
                        dec.illegal = !f7Base;  // Upper imm bits must be zero
                    end
                    rvPkg::F3_SR: begin
                        dec.aluOp   = f7Alt ? rvPkg::SRA : rvPkg::SRL;
                        dec.illegal = !(f7Base || f7Alt);
                    end
                endcase
            end

            rvPkg::OP_B: begin
                dec.imm      = immB;
                dec.isBranch = 1'b1;
                dec.aluOp    = rvPkg::SUB;  // Compare done in ALU
                case (dec.funct3)
                    rvPkg::F3_BEQ, rvPkg::F3_BNE,
                    rvPkg::F3_BLT, rvPkg::F3_BGE,
                    rvPkg::F3_BLTU, rvPkg::F3_BGEU: dec.illegal = 1'b0;
                    default:                        dec.illegal = 1'b1;
                endcase
            end

            default: dec.illegal = 1'b1;  // Unsupported opcode
        endcase

        // Illegal words retire as no-ops
        if (dec.illegal) begin
            dec.regWrite = 1'b0;
            dec.isBranch = 1'b0;
            dec.aluOp    = rvPkg::NONE;
        end
    end

endmodule

//--- pcCounter.sv
`timescale 1ns/1ps

module pcCounter #(
    parameter logic [rvPkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   advance,  // One pulse per retire
    input  logic                   taken,
    input  logic [rvPkg::XLEN-1:0] offset,   // Branch immediate
    output logic [rvPkg::XLEN-1:0] pc
);

    logic [rvPkg::XLEN-1:0] step;
    logic [rvPkg::XLEN-1:0] pcNext;

    // Branch offset or next sequential word
    assign step   = taken ? offset : rvPkg::XLEN'(4);
    assign pcNext = pc + step;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= pcNext;
        end
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [rvPkg::REG_ADDR_W-1:0] rdAddr1,
    input  logic [rvPkg::REG_ADDR_W-1:0] rdAddr2,
    output logic [rvPkg::XLEN-1:0]       rdData1,
    output logic [rvPkg::XLEN-1:0]       rdData2,
    input  logic                         wrEn,
    input  logic [rvPkg::REG_ADDR_W-1:0] wrAddr,
    input  logic [rvPkg::XLEN-1:0]       wrData
);

    localparam int DEPTH = 2 ** rvPkg::REG_ADDR_W;

    logic [rvPkg::XLEN-1:0] regs [DEPTH];
    logic                   wrOk;  // Write allowed except to x0

    assign wrOk = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wrOk) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads with x0 forced to zero
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the rvExecCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbRvExecCore -f rvExecCore.f -o simRvExecCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simRvExecCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1

//--- rvExecCore.f
rvPkg.sv
instrDecode.sv
regFile.sv
alu.sv
pcCounter.sv
execCtrl.sv
rvExecCore.sv
rvExecCore_sva.sv
tbRvExecCore.sv

//--- rvExecCore.sv
`timescale 1ns/1ps

module rvExecCore #(
    parameter logic [rvPkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    output logic                   busy,
    output logic                   done,
    output rvPkg::wbT              wb,
    output logic [rvPkg::XLEN-1:0] pc
);

    logic                   latchEn;
    logic                   exeEn;
    logic                   wbEn;
    logic [31:0]            instrQ;     // Held until retire
    rvPkg::decodeT          dec;
    logic [rvPkg::XLEN-1:0] rdData1;
    logic [rvPkg::XLEN-1:0] rdData2;
    logic [rvPkg::XLEN-1:0] aluResult;
    logic                   aluTaken;
    logic [rvPkg::XLEN-1:0] resultQ;    // Execute stage result
    logic                   takenQ;
    rvPkg::wbT              wbRaw;

    execCtrl uCtrl (
        .clk       (clk),
        .arstN     (arstN),
        .instrValid(instrValid),
        .latchEn   (latchEn),
        .exeEn     (exeEn),
        .wbEn      (wbEn),
        .busy      (busy),
        .done      (done)
    );

    // ------------------------------------------------
    // Instruction and execute registers
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (latchEn) begin
            instrQ <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (exeEn) begin
            resultQ <= aluResult;
            takenQ  <= aluTaken;
        end
    end

    instrDecode uDecode (
        .instr(instrQ),
        .dec  (dec)
    );

    regFile uRegs (
        .clk    (clk),
        .arstN  (arstN),
        .rdAddr1(dec.rs1),
        .rdAddr2(dec.rs2),
        .rdData1(rdData1),
        .rdData2(rdData2),
        .wrEn   (wb.en),    // x0 refused inside
        .wrAddr (wb.rd),
        .wrData (wb.data)
    );

    alu uAlu (
        .rs1Data    (rdData1),
        .rs2Data    (rdData2),
        .dec        (dec),
        .result     (aluResult),
        .branchTaken(aluTaken)
    );

    // ------------------------------------------------
    // Write-back record
    // ------------------------------------------------
    always_comb begin
        wbRaw.en          = dec.regWrite;
        wbRaw.rd          = dec.rd;
        wbRaw.data        = resultQ;
        wbRaw.branchTaken = takenQ;
        wbRaw.illegal     = dec.illegal;
    end

    assign wb = wbEn ? wbRaw : '0;  // Presented only in the retire cycle

    pcCounter #(
        .RESET_PC(RESET_PC)
    ) uPc (
        .clk    (clk),
        .arstN  (arstN),
        .advance(wbEn),
        .taken  (wb.branchTaken),
        .offset (dec.imm),
        .pc     (pc)
    );

endmodule

//--- rvExecCore_sva.sv
`timescale 1ns/1ps

module rvExecCoreSva (
    input logic        clk,
    input logic        arstN,
    input logic        instrValid,
    input logic        busy,
    input logic        done,
    input logic [31:0] pc
);

    // Retire strobe is a single pulse
    doneOnePulse: assert property (@(posedge clk) disable iff (!arstN)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Accepted strobe three edges earlier
    doneLatency: assert property (@(posedge clk) disable iff (!arstN)
        done |-> $past(instrValid && !busy, 3))
        else $error("done without an accepted instruction three cycles before");

    // A busy period lasts exactly three cycles
    busyWindow: assert property (@(posedge clk) disable iff (!arstN)
        (!busy && $past(busy)) |->
            ($past(busy, 2) && $past(busy, 3) && !$past(busy, 4)))
        else $error("busy period did not last exactly three cycles");

    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

bind rvExecCore rvExecCoreSva uSva (
    .clk       (clk),
    .arstN     (arstN),
    .instrValid(instrValid),
    .busy      (busy),
    .done      (done),
    .pc        (pc)
);

//--- rvPkg.sv
package rvPkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------
    localparam int XLEN       = 32;  // Data path width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    // ------------------------------------------------
    // Encodings
    // ------------------------------------------------
    // Any other major opcode is illegal
    typedef enum logic [6:0] {
        OP_R = 7'b0110011,  // Register-register ALU
        OP_I = 7'b0010011,  // Register-immediate ALU
        OP_B = 7'b1100011   // Conditional branch
    } opcodeE;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,   // Signed set-less-than
        SLTU = 4'd9,   // Unsigned set-less-than
        NONE = 4'd15   // Result forced to zero
    } aluOpE;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        DECODE    = 2'd1,
        EXECUTE   = 2'd2,
        WRITEBACK = 2'd3
    } ctrlStateE;

    // ALU funct3 codes, shared by R and I forms
    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // Normal form
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA form

    // ------------------------------------------------
    // Records
    // ------------------------------------------------
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       imm;       // Sign-extended I or B immediate
        logic                  aluSrc;    // Immediate as second operand
        aluOpE                 aluOp;
        logic                  isBranch;
        logic                  regWrite;
        logic                  illegal;
    } decodeT;

    typedef struct packed {
        logic                  en;           // Register write
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  branchTaken;
        logic                  illegal;
    } wbT;

endpackage

//--- tbRvExecCore.sv
`timescale 1ns/1ps

module tbRvExecCore;

    localparam logic [31:0] SEED  = 32'd76140;
    localparam logic [6:0]  OPC_R = 7'b0110011;  // RV32I major opcodes
    localparam logic [6:0]  OPC_I = 7'b0010011;
    localparam logic [6:0]  OPC_B = 7'b1100011;
    localparam logic [6:0]  ALT7  = 7'b0100000;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        busy;
    logic        done;
    rvPkg::wbT   wb;
    logic [31:0] pc;

    logic [31:0] model [32];  // Expected register contents
    logic [31:0] lcgState;
    logic [31:0] pcBefore;    // pc at the strobe
    rvPkg::wbT   wbSeen;      // Record captured with done
    int          latency;
    int          checks;
    int          errors;

    rvExecCore u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .instrValid(instrValid),
        .instr     (instr),
        .busy      (busy),
        .done      (done),
        .wb        (wb),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Encoders and reference rules
    // --------------------------------------------------
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_I};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_B};
    endfunction

    // Signed less than from sign bits, magnitude compare otherwise
    function automatic logic lessSigned(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];  // Only five shift bits count
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << sh;
            3'd2:    r = {31'b0, lessSigned(a, b)};
            3'd3:    r = {31'b0, a < b};
            3'd4:    r = a ^ b;
            3'd5: begin
                r = a >> sh;
                if (alt && a[31]) begin
                    r = r | ~(32'hFFFF_FFFF >> sh);  // Refill with ones
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic refTaken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            rvPkg::F3_BEQ:  return a == b;
            rvPkg::F3_BNE:  return a != b;
            rvPkg::F3_BLT:  return lessSigned(a, b);
            rvPkg::F3_BGE:  return !lessSigned(a, b);
            rvPkg::F3_BLTU: return a < b;
            default:        return a >= b;
        endcase
    endfunction

    // --------------------------------------------------
    // Drive and check helpers
    // --------------------------------------------------
    task automatic expectHex(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", what, exp, act);
            errors++;
        end
    endtask

    // Called on a falling edge and returns on the falling edge after retire
    task automatic issue(input logic [31:0] word);
        int n;
        pcBefore   = pc;
        instr      = word;
        instrValid = 1'b1;
        @(negedge clk);
        instrValid = 1'b0;
        n = 1;
        while (!done && n < 20) begin
            @(negedge clk);
            n++;
        end
        latency = n;
        wbSeen  = wb;
        if (!done) begin
            $display("Timeout: no done within 20 cycles for instruction %h", word);
            errors++;
        end
        @(negedge clk);  // New pc from here
    endtask

    task automatic checkAluRetire(input logic [4:0] rd, input logic [31:0] exp);
        expectHex("latency", 32'd3, 32'(latency));
        expectHex("wb.en", 32'd1, {31'b0, wbSeen.en});
        expectHex("wb.rd", {27'b0, rd}, {27'b0, wbSeen.rd});
        expectHex("wb.data", exp, wbSeen.data);
        expectHex("wb.illegal", 32'd0, {31'b0, wbSeen.illegal});
        expectHex("pc", pcBefore + 32'd4, pc);
    endtask

    task automatic execI(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        logic [31:0] exp;
        exp = refAlu(f3, (f3 == rvPkg::F3_SR) && imm[10], model[rs1], {{20{imm[11]}}, imm});
        issue(encI(imm, rs1, f3, rd));
        checkAluRetire(rd, exp);
        if (rd != 5'd0) begin
            model[rd] = exp;
        end
    endtask

    task automatic execR(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] exp;
        exp = refAlu(f3, alt, model[rs1], model[rs2]);
        issue(encR(alt ? ALT7 : 7'b0, rs2, rs1, f3, rd));
        checkAluRetire(rd, exp);
        if (rd != 5'd0) begin
            model[rd] = exp;
        end
    endtask

    task automatic execB(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [12:0] imm);
        logic taken;
        taken = refTaken(f3, model[rs1], model[rs2]);
        issue(encB(imm, rs2, rs1, f3));
        expectHex("latency", 32'd3, 32'(latency));
        expectHex("wb.branchTaken", {31'b0, taken}, {31'b0, wbSeen.branchTaken});
        expectHex("wb.en", 32'd0, {31'b0, wbSeen.en});
        expectHex("pc", taken ? pcBefore + {{19{imm[12]}}, imm} : pcBefore + 32'd4, pc);
    endtask

    // One taken and one not-taken case per condition
    task automatic branchPair(input logic [2:0] f3, input logic [4:0] aTaken,
                              input logic [4:0] bTaken, input logic [4:0] aNot,
                              input logic [4:0] bNot);
        logic [31:0] r;
        r = nextRand();
        execB(f3, aTaken, bTaken, {f3[0], r[9:0], 2'b00});  // Odd funct3 jumps back
        r = nextRand();
        execB(f3, aNot, bNot, {r[10:0], 2'b00});
    endtask

    // Five steps build any 32-bit value
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
        execI(rvPkg::F3_ADD, rd, 5'd0, {1'b0, v[31:21]});
        execI(rvPkg::F3_SLL, rd, rd, 12'd11);
        execI(rvPkg::F3_OR, rd, rd, {1'b0, v[20:10]});
        execI(rvPkg::F3_SLL, rd, rd, 12'd10);
        execI(rvPkg::F3_OR, rd, rd, {2'b0, v[9:0]});
        expectHex("loaded register", v, wbSeen.data);
    endtask

    task automatic checkIllegal(input logic [31:0] word);
        issue(word);
        expectHex("latency", 32'd3, 32'(latency));
        expectHex("wb.illegal", 32'd1, {31'b0, wbSeen.illegal});
        expectHex("wb.en", 32'd0, {31'b0, wbSeen.en});
        expectHex("pc", pcBefore + 32'd4, pc);
    endtask

    task automatic reportTest(input string name, input int errStart);
        if (errors == errStart) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errStart);
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic testReset();
        int errStart;
        errStart = errors;
        expectHex("done", 32'd0, {31'b0, done});
        expectHex("busy", 32'd0, {31'b0, busy});
        expectHex("pc", 32'h0000_0000, pc);  // Default RESET_PC
        expectHex("wb.data", 32'd0, wb.data);
        reportTest("reset state", errStart);
    endtask

    task automatic testImmOps();
        int          errStart;
        logic [31:0] r;
        errStart = errors;
        r = nextRand();
        execI(rvPkg::F3_ADD, 5'd1, 5'd0, r[11:0]);
        r = nextRand();
        execI(rvPkg::F3_XOR, 5'd2, 5'd1, r[11:0]);
        execI(rvPkg::F3_OR, 5'd3, 5'd1, r[23:12]);
        execI(rvPkg::F3_AND, 5'd4, 5'd1, r[31:20]);
        r = nextRand();
        execI(rvPkg::F3_SLT, 5'd5, 5'd1, r[11:0]);
        execI(rvPkg::F3_SLTU, 5'd6, 5'd1, r[23:12]);
        execI(rvPkg::F3_SLL, 5'd7, 5'd1, {7'b0, r[4:0]});
        execI(rvPkg::F3_SR, 5'd8, 5'd1, {7'b0, r[9:5]});
        execI(rvPkg::F3_SR, 5'd9, 5'd1, {ALT7, r[14:10]});  // SRAI
        reportTest("immediate ops", errStart);
    endtask

    task automatic testRegOps();
        int errStart;
        errStart = errors;
        loadReg(5'd5, nextRand() | 32'h8000_0000);  // Negative
        loadReg(5'd6, nextRand() & 32'h7FFF_FFFF);  // Positive
        loadReg(5'd7, nextRand());                  // Shift amount source
        execR(rvPkg::F3_ADD, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_ADD, 1'b1, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_XOR, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_OR, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_AND, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_SLT, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_SLT, 1'b0, 5'd10, 5'd6, 5'd5);
        execR(rvPkg::F3_SLTU, 1'b0, 5'd10, 5'd5, 5'd6);
        execR(rvPkg::F3_SLTU, 1'b0, 5'd10, 5'd6, 5'd5);
        execR(rvPkg::F3_SLL, 1'b0, 5'd10, 5'd5, 5'd7);
        execR(rvPkg::F3_SR, 1'b0, 5'd10, 5'd5, 5'd7);
        execR(rvPkg::F3_SR, 1'b1, 5'd10, 5'd5, 5'd7);
        reportTest("register ops", errStart);
    endtask

    task automatic testBranches();
        int errStart;
        errStart = errors;
        execI(rvPkg::F3_ADD, 5'd11, 5'd5, 12'd0);  // x11 equals x5
        branchPair(rvPkg::F3_BEQ, 5'd5, 5'd11, 5'd5, 5'd6);
        branchPair(rvPkg::F3_BNE, 5'd5, 5'd6, 5'd5, 5'd11);
        branchPair(rvPkg::F3_BLT, 5'd5, 5'd6, 5'd6, 5'd5);
        branchPair(rvPkg::F3_BGE, 5'd6, 5'd5, 5'd5, 5'd6);
        branchPair(rvPkg::F3_BLTU, 5'd6, 5'd5, 5'd5, 5'd6);
        branchPair(rvPkg::F3_BGEU, 5'd5, 5'd6, 5'd6, 5'd5);
        reportTest("branches", errStart);
    endtask

    task automatic testZeroReg();
        int errStart;
        errStart = errors;
        execI(rvPkg::F3_ADD, 5'd0, 5'd0, 12'h123);
        execR(rvPkg::F3_ADD, 1'b0, 5'd0, 5'd5, 5'd6);
        execR(rvPkg::F3_ADD, 1'b0, 5'd12, 5'd0, 5'd6);  // Reads x0 back
        execR(rvPkg::F3_ADD, 1'b0, 5'd13, 5'd0, 5'd0);
        reportTest("register zero", errStart);
    endtask

    task automatic testDropAndIllegal();
        int          errStart;
        int          doneCount;
        logic [31:0] pcStart;
        logic [4:0]  rdSeen;
        errStart  = errors;
        doneCount = 0;
        rdSeen    = '0;
        pcStart   = pc;
        instr      = encI(12'd5, 5'd0, rvPkg::F3_ADD, 5'd14);
        instrValid = 1'b1;
        @(negedge clk);
        instr = encI(12'd7, 5'd0, rvPkg::F3_ADD, 5'd15);  // Lands while busy
        @(negedge clk);
        instrValid = 1'b0;
        for (int n = 0; n < 8; n++) begin
            if (done) begin
                doneCount++;
                rdSeen = wb.rd;
            end
            @(negedge clk);
        end
        expectHex("done count", 32'd1, 32'(doneCount));
        expectHex("wb.rd", 32'd14, {27'b0, rdSeen});
        expectHex("pc", pcStart + 32'd4, pc);
        model[14] = 32'd5;
        execR(rvPkg::F3_ADD, 1'b0, 5'd16, 5'd15, 5'd0);  // x15 never written
        execR(rvPkg::F3_ADD, 1'b0, 5'd16, 5'd14, 5'd0);
        checkIllegal({12'd7, 5'd1, 3'b010, 5'd17, 7'b0000011});  // Load word
        checkIllegal(encR(ALT7, 5'd6, 5'd5, rvPkg::F3_XOR, 5'd17));
        execR(rvPkg::F3_ADD, 1'b0, 5'd18, 5'd17, 5'd0);  // x17 untouched
        reportTest("dropped strobe and illegal", errStart);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        lcgState   = SEED;
        checks     = 0;
        errors     = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);  // Two clock cycles in reset
        @(negedge clk);
        arstN = 1'b1;

        testReset();
        testImmOps();
        testRegOps();
        testBranches();
        testZeroReg();
        testDropAndIllegal();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
